//--- csr_issue_unit.f
+incdir+include
logic/reg_pkg.sv
logic/csr_pkg.sv
logic/csr_dispatch.sv
logic/csr_issue_fifo.sv
logic/csr_issue.sv
logic/csr_exec.sv
logic/csr_issue_unit.sv
sim/csr_issue_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CSR issue unit testbench with Verilator and runs it.
# The result is taken from the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f csr_issue_unit.f --top-module csr_issue_unit_tb \
	-Mdir obj_dir -o csr_issue_unit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/csr_issue_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$log"; then
	exit 0
fi
echo "Pass line not found in $log"
exit 1

//--- sim/csr_issue_unit_tb.sv
//####################
// Table-driven testbench for the CSR
// issue unit with clock, reset, watchdog,
// stimulus rows and writeback checks.
//####################

`timescale 1ns/1ps
`include "csr_config.svh"

module csr_issue_unit_tb;

	localparam int NUM_ROWS = 15;
	localparam int WB_WAIT = 50;
	localparam int QUIET = 20;

	// Row kinds.
	localparam int NORMAL = 0;
	localparam int ORDER = 1;
	localparam int OPERAND = 2;
	localparam int FLUSH = 3;
	localparam int ILLEGAL = 4;

	logic                       CLK;
	logic                       rst_n;
	logic                       flush;
	logic                       instr_valid;
	logic [2:0]                 funct3;
	csr_pkg::csr_addr_t         csr_addr;
	reg_pkg::preg_t             rd;
	reg_pkg::preg_t             rs1;
	reg_pkg::xdata_t            pc;
	logic [`PREG_NUM*`XLEN-1:0] regfile_read;
	logic [`PREG_NUM-1:0]       wb_log;
	reg_pkg::xdata_t            commit_pc;
	logic                       illegal;
	logic                       csr_full;
	logic                       wb_valid;
	reg_pkg::preg_t             wb_rd;
	reg_pkg::xdata_t            wb_data;

	string                t_name [NUM_ROWS];
	int                   t_mode [NUM_ROWS];
	logic [2:0]           t_funct3 [NUM_ROWS];
	csr_pkg::csr_addr_t   t_addr [NUM_ROWS];
	reg_pkg::preg_t       t_rd [NUM_ROWS];
	reg_pkg::preg_t       t_rs1 [NUM_ROWS];
	reg_pkg::xdata_t      t_pc [NUM_ROWS];
	logic [`PREG_NUM-1:0] t_log [NUM_ROWS];
	reg_pkg::xdata_t      t_exp [NUM_ROWS];
	reg_pkg::xdata_t      regval [`PREG_NUM];
	int                   row_fails;
	int                   errors;
	int                   passed;

	csr_issue_unit csr_issue_unit_inst (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .instr_valid(instr_valid),
		.funct3(funct3), .csr_addr(csr_addr), .rd(rd), .rs1(rs1), .pc(pc),
		.regfile_read(regfile_read), .wb_log(wb_log), .commit_pc(commit_pc),
		.illegal(illegal), .csr_full(csr_full), .wb_valid(wb_valid),
		.wb_rd(wb_rd), .wb_data(wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Worst case per row plus reset margin.
	initial begin
		repeat (NUM_ROWS * 60 + 200) @(posedge CLK);
		$display("Watchdog expired, the test sequence did not finish");
		$display("Test FAILED");
		$finish;
	end

	function automatic reg_pkg::preg_t phys(input int arch, input int ren);
		return reg_pkg::preg_t'((arch << `RB) + ren);
	endfunction

	function automatic logic [`PREG_NUM-1:0] log_without(input reg_pkg::preg_t p);
		logic [`PREG_NUM-1:0] m;
		m = '1;
		m[p] = 1'b0;
		return m;
	endfunction

	function automatic void set_row(input int i, input string name, input int mode,
		input logic [2:0] f3, input csr_pkg::csr_addr_t addr, input reg_pkg::preg_t rd_i,
		input reg_pkg::preg_t rs1_i, input reg_pkg::xdata_t pc_i,
		input logic [`PREG_NUM-1:0] log_i, input reg_pkg::xdata_t exp_i);
		t_name[i] = name;
		t_mode[i] = mode;
		t_funct3[i] = f3;
		t_addr[i] = addr;
		t_rd[i] = rd_i;
		t_rs1[i] = rs1_i;
		t_pc[i] = pc_i;
		t_log[i] = log_i;
		t_exp[i] = exp_i;
	endfunction

	// Expected values follow the rw / set / clear rules step by step.
	function automatic void build_table();
		reg_pkg::xdata_t a, b, c, d;
		logic [`PREG_NUM-1:0] all;
		a = regval[phys(5, 1)];
		b = regval[phys(6, 2)];
		c = regval[phys(7, 3)];
		d = regval[phys(8, 1)];
		all = '1;
		set_row(0, "csrrw_mscratch", NORMAL, 3'd1, `CSR_MSCRATCH, phys(10, 0), phys(5, 1),
			64'h1000, all, 64'h0);
		set_row(1, "csrrs_x0_readback", NORMAL, 3'd2, `CSR_MSCRATCH, phys(11, 0), phys(0, 0),
			64'h1004, log_without(phys(0, 0)), a);
		set_row(2, "csrrs_mscratch", NORMAL, 3'd2, `CSR_MSCRATCH, phys(11, 1), phys(6, 2),
			64'h1008, all, a);
		set_row(3, "csrrc_mscratch", NORMAL, 3'd3, `CSR_MSCRATCH, phys(12, 1), phys(7, 3),
			64'h100c, all, a | b);
		set_row(4, "csrrwi_mtvec", NORMAL, 3'd5, `CSR_MTVEC, phys(13, 0), phys(5'h15, 0),
			64'h1010, log_without(phys(5'h15, 0)), 64'h0);
		set_row(5, "csrrsi_mtvec", NORMAL, 3'd6, `CSR_MTVEC, phys(14, 1), phys(5'h0a, 0),
			64'h1014, all, 64'h15);
		set_row(6, "csrrci_mtvec", NORMAL, 3'd7, `CSR_MTVEC, phys(15, 2), phys(5'h03, 0),
			64'h1018, all, 64'h1f);
		set_row(7, "commit_order_wait", ORDER, 3'd1, `CSR_MCAUSE, phys(16, 0), phys(8, 1),
			64'h101c, all, 64'h0);
		set_row(8, "operand_wait", OPERAND, 3'd2, `CSR_MCAUSE, phys(17, 0), phys(9, 2),
			64'h1020, log_without(phys(9, 2)), d);
		set_row(9, "flush_queue", FLUSH, 3'd1, `CSR_MSCRATCH, phys(18, 0), phys(12, 0),
			64'h2000, all, 64'h0);
		set_row(10, "mscratch_after_flush", NORMAL, 3'd2, `CSR_MSCRATCH, phys(19, 0),
			phys(0, 1), 64'h1024, all, (a | b) & ~c);
		// Odd immediate, so bit 0 has to come back clear.
		set_row(11, "csrrwi_mepc", NORMAL, 3'd5, `CSR_MEPC, phys(20, 0), phys(5'h13, 0),
			64'h1028, all, 64'h0);
		set_row(12, "mepc_readback", NORMAL, 3'd2, `CSR_MEPC, phys(21, 0), phys(0, 2),
			64'h102c, all, 64'h12);
		set_row(13, "unknown_address", NORMAL, 3'd1, 12'h7c0, phys(22, 0), phys(14, 0),
			64'h1030, all, 64'h0);
		set_row(14, "illegal_funct3", ILLEGAL, 3'd4, `CSR_MSCRATCH, phys(23, 0), phys(5, 1),
			64'h1034, all, 64'h0);
	endfunction

	// Leaves instr_valid high; the caller drops it.
	task automatic drive_instr(input int i, input reg_pkg::xdata_t pc_i);
		@(negedge CLK);
		instr_valid = 1'b1;
		funct3 = t_funct3[i];
		csr_addr = t_addr[i];
		rd = t_rd[i];
		rs1 = t_rs1[i];
		pc = pc_i;
	endtask

	task automatic expect_quiet(input int i);
		repeat (QUIET) begin
			@(negedge CLK);
			if (wb_valid) begin
				$display("%s: unexpected writeback to register %h", t_name[i], wb_rd);
				row_fails++;
			end
		end
	endtask

	task automatic check_writeback(input int i);
		int waited;
		waited = 0;
		@(negedge CLK);
		while (!wb_valid && waited < WB_WAIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!wb_valid) begin
			$display("%s: no writeback within %0d cycles", t_name[i], WB_WAIT);
			row_fails++;
		end else begin
			if (wb_data !== t_exp[i]) begin
				$display("[FAIL] %s expected %h actual %h", t_name[i], t_exp[i], wb_data);
				row_fails++;
			end
			if (wb_rd !== t_rd[i]) begin
				$display("[FAIL] %s expected %h actual %h", t_name[i], t_rd[i], wb_rd);
				row_fails++;
			end
		end
	endtask

	task automatic run_row(input int i);
		wb_log = t_log[i];
		if (t_mode[i] == FLUSH) begin
			// Park a full queue behind a commit PC that never matches.
			commit_pc = 64'hdead_beef_0000_0000;
			for (int k = 0; k < `CSR_FIFO_DEPTH; k++) begin
				drive_instr(i, t_pc[i] + 64'(4 * k));
			end
			@(negedge CLK);
			instr_valid = 1'b0;
			@(negedge CLK);
			if (!csr_full) begin
				$display("%s: queue did not report full", t_name[i]);
				row_fails++;
			end
			flush = 1'b1;
			@(negedge CLK);
			flush = 1'b0;
			if (csr_full) begin
				$display("%s: queue still full after flush", t_name[i]);
				row_fails++;
			end
			commit_pc = t_pc[i];
			expect_quiet(i);
		end else begin
			drive_instr(i, t_pc[i]);
			@(negedge CLK);
			instr_valid = 1'b0;
			if (t_mode[i] == ILLEGAL) begin
				if (!illegal) begin
					$display("%s: illegal did not pulse", t_name[i]);
					row_fails++;
				end
				commit_pc = t_pc[i];
				expect_quiet(i);
			end else begin
				if (t_mode[i] == ORDER) begin
					commit_pc = t_pc[i] + 64'h100;
					expect_quiet(i);
				end
				commit_pc = t_pc[i];
				if (t_mode[i] == OPERAND) begin
					expect_quiet(i);
					wb_log[t_rs1[i]] = 1'b1;
				end
				check_writeback(i);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h7431_f260));
		rst_n = 1'b0;
		flush = 1'b0;
		instr_valid = 1'b0;
		funct3 = '0;
		csr_addr = '0;
		rd = '0;
		rs1 = '0;
		pc = '0;
		wb_log = '0;
		commit_pc = '0;
		errors = 0;
		passed = 0;
		// x0 and its rename copies hold zero.
		for (int p = 0; p < `PREG_NUM; p++) begin
			regval[p] = ((p >> `RB) == 0) ? '0 : {$urandom, $urandom};
			regfile_read[p*`XLEN +: `XLEN] = regval[p];
		end
		build_table();
		repeat (16) @(negedge CLK);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			row_fails = 0;
			run_row(i);
			if (row_fails == 0) begin
				$display("[PASS] %s", t_name[i]);
				passed++;
			end else begin
				$display("%s: %0d checks failed", t_name[i], row_fails);
				errors += row_fails;
			end
		end
		$display("%0d tests, %0d passed, %0d failed checks", NUM_ROWS, passed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- logic/csr_issue_unit.sv
//####################
// csr_issue_unit: dispatch, queue,
// issue and CSR executor.
//####################

`timescale 1ns/1ps
`include "csr_config.svh"

module csr_issue_unit (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic                       flush,
	input  logic                       instr_valid,
	input  logic [2:0]                 funct3,
	input  csr_pkg::csr_addr_t         csr_addr,
	input  reg_pkg::preg_t             rd,
	input  reg_pkg::preg_t             rs1,
	input  reg_pkg::xdata_t            pc,
	input  logic [`PREG_NUM*`XLEN-1:0] regfile_read,
	input  logic [`PREG_NUM-1:0]       wb_log,
	input  reg_pkg::xdata_t            commit_pc,
	output logic                       illegal,
	output logic                       csr_full,
	output logic                       wb_valid,
	output reg_pkg::preg_t             wb_rd,
	output reg_pkg::xdata_t            wb_data
);

	logic                push;
	csr_pkg::csr_entry_t entry;
	csr_pkg::csr_entry_t head;
	logic                empty;
	logic                pop;
	logic                exe_valid;
	csr_pkg::csr_exe_t   exe;

	csr_dispatch csr_dispatch_inst (
		.CLK(CLK), .rst_n(rst_n), .instr_valid(instr_valid), .funct3(funct3),
		.csr_addr(csr_addr), .rd(rd), .rs1(rs1), .pc(pc),
		.push(push), .illegal(illegal), .entry(entry)
	);

	csr_issue_fifo csr_issue_fifo_inst (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .push(push), .entry_in(entry),
		.pop(pop), .head(head), .empty(empty), .full(csr_full)
	);

	// Waits on commit_pc and wb_log.
	csr_issue csr_issue_inst (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .empty(empty), .info(head),
		.pop(pop), .regfile_read(regfile_read), .wb_log(wb_log),
		.commit_pc(commit_pc), .exe_valid(exe_valid), .exe(exe)
	);

	// Always accepts, so no ready back to issue.
	csr_exec csr_exec_inst (
		.CLK(CLK), .rst_n(rst_n), .exe_valid(exe_valid), .exe(exe),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

//--- logic/csr_exec.sv
//####################
// csr_exec: machine-mode CSR file,
// read-write, set and clear, and
// writeback of the old value.
//####################

`timescale 1ns/1ps
`include "csr_config.svh"

module csr_exec (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              exe_valid,
	input  csr_pkg::csr_exe_t exe,
	output logic              wb_valid,
	output reg_pkg::preg_t    wb_rd,
	output reg_pkg::xdata_t   wb_data
);

	logic               kind_rw;
	logic               kind_rs;
	logic               kind_rc;
	reg_pkg::preg_t     rd;
	reg_pkg::xdata_t    operand;
	csr_pkg::csr_addr_t addr;
	reg_pkg::xdata_t    old_val;
	reg_pkg::xdata_t    new_val;
	reg_pkg::xdata_t    mscratch;
	reg_pkg::xdata_t    mepc;
	reg_pkg::xdata_t    mtvec;
	reg_pkg::xdata_t    mcause;

	assign {kind_rw, kind_rs, kind_rc, rd, operand, addr} = exe;

	// Unknown addresses read as zero.
	always_comb begin
		case (addr)
			`CSR_MSCRATCH: old_val = mscratch;
			`CSR_MEPC: old_val = mepc;
			`CSR_MTVEC: old_val = mtvec;
			`CSR_MCAUSE: old_val = mcause;
			default: old_val = '0;
		endcase
	end

	always_comb begin
		if (kind_rw) begin
			new_val = operand;
		end else if (kind_rs) begin
			new_val = old_val | operand;
		end else begin
			new_val = old_val & ~operand;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mscratch <= '0;
			mepc <= '0;
			mtvec <= '0;
			mcause <= '0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
			if (exe_valid) begin
				case (addr)
					`CSR_MSCRATCH: mscratch <= new_val;
					// Instructions are at least halfword aligned.
					`CSR_MEPC: mepc <= {new_val[`XLEN-1:1], 1'b0};
					`CSR_MTVEC: mtvec <= new_val;
					`CSR_MCAUSE: mcause <= new_val;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb_rd <= rd;
			wb_data <= old_val;
		end
	end

	one_kind: assert property (@(posedge CLK) disable iff (!rst_n)
		exe_valid |-> $onehot({kind_rw, kind_rs, kind_rc}));

endmodule

//--- logic/csr_issue.sv
//####################
// csr_issue: commit-order and operand
// wait, operand read, registered
// execute parameter.
//####################

`timescale 1ns/1ps
`include "csr_config.svh"

module csr_issue (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  logic                              flush,
	input  logic                              empty,
	input  csr_pkg::csr_entry_t               info,
	output logic                              pop,
	input  logic [`PREG_NUM*`XLEN-1:0]        regfile_read,
	input  logic [`PREG_NUM-1:0]              wb_log,
	input  reg_pkg::xdata_t                   commit_pc,
	output logic                              exe_valid,
	output csr_pkg::csr_exe_t                 exe
);

	csr_pkg::csr_op_t   op;
	reg_pkg::xdata_t    issue_pc;
	csr_pkg::csr_addr_t addr;
	reg_pkg::preg_t     rd;
	reg_pkg::preg_t     rs1;
	reg_pkg::areg_t     rs1_arch;
	reg_pkg::xdata_t    operand;
	csr_pkg::csr_exe_t  exe_next;
	logic               reg_form;
	logic               imm_form;
	logic               rs1_ready;
	logic               order_ok;
	logic               issue;

	assign {op, issue_pc, addr, rd, rs1} = info;
	assign rs1_arch = rs1[`RB +: 5];

	assign reg_form = |op[5:3];
	assign imm_form = |op[2:0];

	// x0 never waits for writeback.
	assign rs1_ready = wb_log[rs1] | (rs1_arch == 5'd0);

	// Only the committing instruction may touch a CSR.
	assign order_ok = (commit_pc == issue_pc);

	assign issue = ~flush & ~empty & order_ok & (imm_form | (reg_form & rs1_ready));
	assign pop = issue;

	// Immediate forms use the zero-extended rs1 field.
	assign operand = reg_form ? regfile_read[rs1 * `XLEN +: `XLEN]
		: {{(`XLEN-5){1'b0}}, rs1_arch};

	// Merge register and immediate kinds.
	assign exe_next = {op[5] | op[2], op[4] | op[1], op[3] | op[0], rd, operand, addr};

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= issue;
		end
	end

	always_ff @(posedge CLK) begin
		if (flush) begin
			exe <= '0;
		end else if (issue) begin
			exe <= exe_next;
		end
	end

	// Every execute comes from a queued entry.
	valid_from_queue: assert property (@(posedge CLK) disable iff (!rst_n)
		exe_valid |-> $past(!empty));

endmodule

//--- logic/csr_issue_fifo.sv
//####################
// csr_issue_fifo: in-order queue of
// CSR entries, flushable.
//####################

`timescale 1ns/1ps
`include "csr_config.svh"

module csr_issue_fifo (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                push,
	input  csr_pkg::csr_entry_t entry_in,
	input  logic                pop,
	output csr_pkg::csr_entry_t head,
	output logic                empty,
	output logic                full
);

	localparam int DEPTH = `CSR_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	csr_pkg::csr_entry_t mem [DEPTH];
	logic [AW-1:0]       wr_ptr;
	logic [AW-1:0]       rd_ptr;
	logic [CW-1:0]       count;
	logic                do_push;
	logic                do_pop;

	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign head = mem[rd_ptr];

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// Payload storage.
	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= entry_in;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Upstream must hold off while full.
	push_not_full: assert property (@(posedge CLK) disable iff (!rst_n)
		!(push && full));

	pop_not_empty: assert property (@(posedge CLK) disable iff (!rst_n)
		!(pop && empty));

endmodule

//--- logic/csr_dispatch.sv
//####################
// csr_dispatch: funct3 decode and
// registered queue entry.
//####################

`timescale 1ns/1ps

module csr_dispatch (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  logic [2:0]          funct3,
	input  csr_pkg::csr_addr_t  csr_addr,
	input  reg_pkg::preg_t      rd,
	input  reg_pkg::preg_t      rs1,
	input  reg_pkg::xdata_t     pc,
	output logic                push,
	output logic                illegal,
	output csr_pkg::csr_entry_t entry
);

	csr_pkg::csr_op_t op;
	logic             reserved;

	// Zicsr funct3 to one-hot flags.
	always_comb begin
		op = '0;
		reserved = 1'b0;
		case (funct3)
			3'd1: op = 6'b100000;
			3'd2: op = 6'b010000;
			3'd3: op = 6'b001000;
			3'd5: op = 6'b000100;
			3'd6: op = 6'b000010;
			3'd7: op = 6'b000001;
			// Codes 0 and 4 are not CSR ops.
			default: reserved = 1'b1;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			push <= 1'b0;
			illegal <= 1'b0;
		end else begin
			push <= instr_valid & ~reserved;
			illegal <= instr_valid & reserved;
		end
	end

	always_ff @(posedge CLK) begin
		if (instr_valid && !reserved) begin
			entry <= {op, pc, csr_addr, rd, rs1};
		end
	end

endmodule

//--- logic/csr_pkg.sv
//####################
// CSR operation types: address,
// operation flags, queue entry
// and execute parameter.
//####################

`include "csr_config.svh"

package csr_pkg;

	// Twelve-bit CSR address.
	typedef logic [11:0] csr_addr_t;

	// One-hot flags, msb first: rw, rs, rc, rwi, rsi, rci.
	typedef logic [5:0] csr_op_t;

	// Queue entry, packed as {op, pc, addr, rd, rs1}.
	typedef logic [`CSR_ENTRY_DW-1:0] csr_entry_t;

	// Execute parameter, packed as {rw, rs, rc, rd, operand, addr}.
	typedef logic [`CSR_EXE_DW-1:0] csr_exe_t;

endpackage

//--- logic/reg_pkg.sv
//####################
// Register-file types: data word,
// physical and architectural index.
//####################

`include "csr_config.svh"

package reg_pkg;

	// One register value.
	typedef logic [`XLEN-1:0] xdata_t;

	// Physical index, architectural index in the upper five bits.
	typedef logic [`PREG_W-1:0] preg_t;

	// Architectural index.
	// Also carries the 5-bit immediate of the i-forms.
	typedef logic [4:0] areg_t;

endpackage

//--- include/csr_config.svh
//####################
// Widths, rename bits, queue depth
// and machine-mode CSR addresses.
//####################

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define XLEN 64
`define RB 2
`define PREG_W (5 + `RB)
`define PREG_NUM (1 << `PREG_W)

`define CSR_FIFO_DEPTH 4

// Op flags, pc, address, rd, rs1.
`define CSR_ENTRY_DW (6 + `XLEN + 12 + 2 * `PREG_W)
// Kind bits, rd, operand, address.
`define CSR_EXE_DW (3 + `PREG_W + `XLEN + 12)

`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MTVEC 12'h305
`define CSR_MCAUSE 12'h342

`endif
